// ==== logic/periph_pkg.sv ====
// Peripheral subsystem shared definitions
// Address map, register word indices and the bus address view
`default_nettype none

package periph_pkg;

  localparam int PAGE_W     = 20;
  localparam int IDX_W      = 4;
  localparam int REG_WORD_W = 6;

  // Subsystem answers at 0x4000_0000, one 256-byte window per peripheral
  localparam logic [PAGE_W-1:0] PERIPH_PAGE = 20'h40000;

  localparam logic [IDX_W-1:0] IDX_IRQ   = 4'd0;
  localparam logic [IDX_W-1:0] IDX_GPIO  = 4'd1;
  localparam logic [IDX_W-1:0] IDX_TIMER = 4'd2;

  // GPIO registers
  localparam logic [REG_WORD_W-1:0] GPIO_IN          = 6'd0;
  localparam logic [REG_WORD_W-1:0] GPIO_OUT         = 6'd1;
  localparam logic [REG_WORD_W-1:0] GPIO_OUT_EN      = 6'd2;
  localparam logic [REG_WORD_W-1:0] GPIO_INTR_EN     = 6'd3;
  localparam logic [REG_WORD_W-1:0] GPIO_INTR_STATUS = 6'd4;

  // Timer registers, CTRL bit 0 counts, bit 1 enables the interrupt
  localparam logic [REG_WORD_W-1:0] TMR_MTIME    = 6'd0;
  localparam logic [REG_WORD_W-1:0] TMR_MTIMECMP = 6'd1;
  localparam logic [REG_WORD_W-1:0] TMR_CTRL     = 6'd2;

  // Interrupt controller registers
  localparam logic [REG_WORD_W-1:0] IRQ_PENDING = 6'd0;
  localparam logic [REG_WORD_W-1:0] IRQ_ENABLE  = 6'd1;
  localparam logic [REG_WORD_W-1:0] IRQ_CLAIM   = 6'd2;
  localparam logic [REG_WORD_W-1:0] IRQ_MSIP    = 6'd3;

  // Sources: 0 reserved, 1..GPIO_W pins, then timer, then external lines

  // Bus address, either as one word or split into its fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [PAGE_W-1:0]     page;
      logic [IDX_W-1:0]      idx;
      logic [REG_WORD_W-1:0] word;
      logic [1:0]            offset;
    } f;
  } periph_addr_u;

endpackage

`default_nettype wire

// ==== logic/obi_reg_bridge.sv ====
// OBI slave to register bus bridge
// Grants every request at once and returns the response one cycle later
`default_nettype none

module obi_reg_bridge (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        reg_valid_o,
  output logic        reg_write_o,
  output logic [31:0] reg_addr_o,
  output logic [31:0] reg_wdata_o,
  input  logic [31:0] reg_rdata_i
);

  import periph_pkg::*;

  periph_addr_u word_addr;
  logic         rvalid_q;
  logic [31:0]  rdata_q;

  // Full word accesses only so the byte offset is dropped
  always_comb begin
    word_addr.raw      = addr_i;
    word_addr.f.offset = 2'b00;
  end

  assign gnt_o       = req_i;
  assign reg_valid_o = req_i;
  assign reg_write_o = we_i;
  assign reg_addr_o  = word_addr.raw;
  assign reg_wdata_o = wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= 32'h0;
    end else begin
      rvalid_q <= req_i;
      // Writes answer with zero data
      if (req_i) begin
        rdata_q <= we_i ? 32'h0 : reg_rdata_i;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== logic/periph_reg_decode.sv ====
// Register bus address decoder
// Strobes one peripheral and muxes its read data back
`default_nettype none

module periph_reg_decode (
  input  logic                              reg_valid_i,
  input  logic                              reg_write_i,
  input  logic [31:0]                       reg_addr_i,
  input  logic [31:0]                       reg_wdata_i,
  output logic [31:0]                       reg_rdata_o,
  output logic                              sel_irq_o,
  output logic                              sel_gpio_o,
  output logic                              sel_timer_o,
  output logic                              wr_o,
  output logic [periph_pkg::REG_WORD_W-1:0] word_o,
  output logic [31:0]                       wdata_o,
  input  logic [31:0]                       irq_rdata_i,
  input  logic [31:0]                       gpio_rdata_i,
  input  logic [31:0]                       timer_rdata_i
);

  import periph_pkg::*;

  periph_addr_u addr;
  logic         page_hit;
  logic         access;

  assign addr.raw = reg_addr_i;
  assign page_hit = (addr.f.page == PERIPH_PAGE);
  assign access   = reg_valid_i & page_hit;

  assign sel_irq_o   = access & (addr.f.idx == IDX_IRQ);
  assign sel_gpio_o  = access & (addr.f.idx == IDX_GPIO);
  assign sel_timer_o = access & (addr.f.idx == IDX_TIMER);

  assign wr_o    = reg_write_i;
  assign word_o  = addr.f.word;
  assign wdata_o = reg_wdata_i;

  // Unmapped page or index reads as zero
  always_comb begin
    reg_rdata_o = 32'h0;
    if (page_hit) begin
      case (addr.f.idx)
        IDX_IRQ: begin
          reg_rdata_o = irq_rdata_i;
        end
        IDX_GPIO: begin
          reg_rdata_o = gpio_rdata_i;
        end
        IDX_TIMER: begin
          reg_rdata_o = timer_rdata_i;
        end
        default: begin
          reg_rdata_o = 32'h0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/gpio_block.sv ====
// GPIO peripheral
// Output and enable registers, input synchronizer, rising-edge interrupts
`default_nettype none

module gpio_block #(
  parameter int GPIO_W = 8
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              sel_i,
  input  logic                              wr_i,
  input  logic [periph_pkg::REG_WORD_W-1:0] word_i,
  input  logic [31:0]                       wdata_i,
  output logic [31:0]                       rdata_o,
  input  logic [GPIO_W-1:0]                 gpio_i,
  output logic [GPIO_W-1:0]                 gpio_o,
  output logic [GPIO_W-1:0]                 gpio_en_o,
  output logic [GPIO_W-1:0]                 intr_o
);

  import periph_pkg::*;

  logic [31:0]       out_q;
  logic [31:0]       oe_q;
  logic [GPIO_W-1:0] intr_en_q;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;
  logic [GPIO_W-1:0] status_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] clr;
  logic              wr_en;

  assign wr_en = sel_i & wr_i;

  // Edge seen one cycle after the synchronized level
  assign rise = sync2_q & ~prev_q & intr_en_q;
  assign clr  = (wr_en && word_i == GPIO_INTR_STATUS) ? wdata_i[GPIO_W-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      status_q  <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      status_q <= (status_q & ~clr) | rise;
      if (wr_en) begin
        case (word_i)
          GPIO_OUT:     out_q     <= wdata_i;
          GPIO_OUT_EN:  oe_q      <= wdata_i;
          GPIO_INTR_EN: intr_en_q <= wdata_i[GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = 32'h0;
    case (word_i)
      GPIO_IN:          rdata_o[GPIO_W-1:0] = sync2_q;
      GPIO_OUT:         rdata_o = out_q;
      GPIO_OUT_EN:      rdata_o = oe_q;
      GPIO_INTR_EN:     rdata_o[GPIO_W-1:0] = intr_en_q;
      GPIO_INTR_STATUS: rdata_o[GPIO_W-1:0] = status_q;
      default:          rdata_o = 32'h0;
    endcase
  end

  assign gpio_o    = out_q[GPIO_W-1:0];
  assign gpio_en_o = oe_q[GPIO_W-1:0];
  assign intr_o    = status_q;

endmodule

`default_nettype wire

// ==== logic/timer_block.sv ====
// Machine timer
// Free-running mtime with a compare register and a level interrupt
`default_nettype none

module timer_block (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              sel_i,
  input  logic                              wr_i,
  input  logic [periph_pkg::REG_WORD_W-1:0] word_i,
  input  logic [31:0]                       wdata_i,
  output logic [31:0]                       rdata_o,
  output logic                              intr_o
);

  import periph_pkg::*;

  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic [1:0]  ctrl_q;
  logic        wr_en;

  assign wr_en = sel_i & wr_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '0;
      ctrl_q     <= '0;
    end else begin
      // A software write to mtime overrides the increment
      if (wr_en && word_i == TMR_MTIME) begin
        mtime_q <= wdata_i;
      end else if (ctrl_q[0]) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr_en && word_i == TMR_MTIMECMP) begin
        mtimecmp_q <= wdata_i;
      end
      if (wr_en && word_i == TMR_CTRL) begin
        ctrl_q <= wdata_i[1:0];
      end
    end
  end

  always_comb begin
    rdata_o = 32'h0;
    case (word_i)
      TMR_MTIME:    rdata_o = mtime_q;
      TMR_MTIMECMP: rdata_o = mtimecmp_q;
      TMR_CTRL:     rdata_o[1:0] = ctrl_q;
      default:      rdata_o = 32'h0;
    endcase
  end

  // Needs both count and interrupt enable
  assign intr_o = ctrl_q[0] & ctrl_q[1] & (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// ==== logic/irq_ctrl.sv ====
// Interrupt controller, single target
// Pending latches, enables, lowest-number claim and software interrupt
`default_nettype none

module irq_ctrl #(
  parameter int GPIO_W  = 8,
  parameter int NUM_EXT = 4
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              sel_i,
  input  logic                              wr_i,
  input  logic [periph_pkg::REG_WORD_W-1:0] word_i,
  input  logic [31:0]                       wdata_i,
  output logic [31:0]                       rdata_o,
  input  logic [GPIO_W-1:0]                 gpio_intr_i,
  input  logic                              timer_intr_i,
  input  logic [NUM_EXT-1:0]                ext_intr_i,
  output logic                              irq_o,
  output logic                              msip_o
);

  import periph_pkg::*;

  localparam int NUM_SRC = GPIO_W + NUM_EXT + 2;
  localparam int ID_W    = $clog2(NUM_SRC);

  logic [NUM_SRC-1:0] src;
  logic [NUM_SRC-1:0] pending_q;
  logic [NUM_SRC-1:0] enable_q;
  logic [NUM_SRC-1:0] active;
  logic [NUM_SRC-1:0] claim_mask;
  logic [ID_W-1:0]    claim_id;
  logic               claim_rd;
  logic               wr_en;
  logic               msip_q;

  // Source 0 is reserved and never pends
  assign src      = {ext_intr_i, timer_intr_i, gpio_intr_i, 1'b0};
  assign active   = pending_q & enable_q;
  assign wr_en    = sel_i & wr_i;
  assign claim_rd = sel_i & ~wr_i & (word_i == IRQ_CLAIM);

  // Scan downwards so the lowest active source is left
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = ID_W'(i);
      end
    end
  end

  always_comb begin
    claim_mask           = '0;
    claim_mask[claim_id] = claim_rd;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
    end else begin
      pending_q <= (pending_q | src) & ~claim_mask;
      if (wr_en && word_i == IRQ_ENABLE) begin
        enable_q <= wdata_i[NUM_SRC-1:0];
      end
      if (wr_en && word_i == IRQ_MSIP) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    rdata_o = 32'h0;
    case (word_i)
      IRQ_PENDING: rdata_o[NUM_SRC-1:0] = pending_q;
      IRQ_ENABLE:  rdata_o[NUM_SRC-1:0] = enable_q;
      IRQ_CLAIM:   rdata_o[ID_W-1:0] = claim_id;
      IRQ_MSIP:    rdata_o[0] = msip_q;
      default:     rdata_o = 32'h0;
    endcase
  end

  assign irq_o  = |active;
  assign msip_o = msip_q;

endmodule

`default_nettype wire

// ==== logic/peripheral_subsystem.sv ====
// Peripheral subsystem top level
// OBI bridge, address decode, GPIO, timer and interrupt controller
`default_nettype none

module peripheral_subsystem #(
  parameter int GPIO_W  = 8,
  parameter int NUM_EXT = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i,
  input  logic [31:0]        addr_i,
  input  logic               we_i,
  input  logic [3:0]         be_i,
  input  logic [31:0]        wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output logic [31:0]        rdata_o,
  input  logic [GPIO_W-1:0]  gpio_i,
  output logic [GPIO_W-1:0]  gpio_o,
  output logic [GPIO_W-1:0]  gpio_en_o,
  input  logic [NUM_EXT-1:0] ext_intr_i,
  output logic               irq_o,
  output logic               msip_o,
  output logic               timer_intr_o
);

  import periph_pkg::*;

  logic                  reg_valid;
  logic                  reg_write;
  logic [31:0]           reg_addr;
  logic [31:0]           reg_wdata;
  logic [31:0]           reg_rdata;
  logic                  sel_irq;
  logic                  sel_gpio;
  logic                  sel_timer;
  logic                  per_wr;
  logic [REG_WORD_W-1:0] per_word;
  logic [31:0]           per_wdata;
  logic [31:0]           irq_rdata;
  logic [31:0]           gpio_rdata;
  logic [31:0]           timer_rdata;
  logic [GPIO_W-1:0]     gpio_intr;

  // be_i stays open, every write is a full word
  obi_reg_bridge obi_reg_bridge_i (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .reg_valid_o (reg_valid),
    .reg_write_o (reg_write),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata)
  );

  periph_reg_decode periph_reg_decode_i (
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_write),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .sel_irq_o     (sel_irq),
    .sel_gpio_o    (sel_gpio),
    .sel_timer_o   (sel_timer),
    .wr_o          (per_wr),
    .word_o        (per_word),
    .wdata_o       (per_wdata),
    .irq_rdata_i   (irq_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata)
  );

  gpio_block #(
    .GPIO_W (GPIO_W)
  ) gpio_block_i (
    .clk_i,
    .arst_n_i,
    .sel_i     (sel_gpio),
    .wr_i      (per_wr),
    .word_i    (per_word),
    .wdata_i   (per_wdata),
    .rdata_o   (gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_o    (gpio_intr)
  );

  timer_block timer_block_i (
    .clk_i,
    .arst_n_i,
    .sel_i   (sel_timer),
    .wr_i    (per_wr),
    .word_i  (per_word),
    .wdata_i (per_wdata),
    .rdata_o (timer_rdata),
    .intr_o  (timer_intr_o)
  );

  irq_ctrl #(
    .GPIO_W  (GPIO_W),
    .NUM_EXT (NUM_EXT)
  ) irq_ctrl_i (
    .clk_i,
    .arst_n_i,
    .sel_i        (sel_irq),
    .wr_i         (per_wr),
    .word_i       (per_word),
    .wdata_i      (per_wdata),
    .rdata_o      (irq_rdata),
    .gpio_intr_i  (gpio_intr),
    .timer_intr_i (timer_intr_o),
    .ext_intr_i,
    .irq_o,
    .msip_o
  );

endmodule

`default_nettype wire

// ==== sim/periph_checker.sv ====
// Response and output checker for the peripheral subsystem
// Compares OBI read data and output lines with queued expected values
`default_nettype none

module periph_checker #(
  parameter int GPIO_W = 8
) (
  input logic              clk_i,
  input logic              rvalid_i,
  input logic [31:0]       rdata_i,
  input logic [GPIO_W-1:0] gpio_i,
  input logic [GPIO_W-1:0] gpio_en_i,
  input logic              irq_i,
  input logic              msip_i,
  input logic              timer_intr_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] exp_q[$];
  bit          min_q[$];
  int          errors = 0;
  int          test_errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  function automatic void count_error();
    errors++;
    test_errors++;
  endfunction

  // Responses come back in request order
  always @(negedge clk_i) begin : response_check
    logic [31:0] want;
    bit          at_least;
    if (rvalid_i) begin
      if (exp_q.size() == 0) begin
        $display("A response arrived at %0t with no request outstanding", $time);
        count_error();
      end else begin
        want     = exp_q.pop_front();
        at_least = min_q.pop_front();
        checks++;
        if (at_least ? ((rdata_i >= want) !== 1'b1) : (rdata_i !== want)) begin
          $display("FAILED at %0t: read data %08h, expected %s%08h", $time, rdata_i,
                   at_least ? "at least " : "", want);
          count_error();
        end
      end
    end
  end

  function automatic void expect_response(input logic [31:0] value, input bit at_least);
    exp_q.push_back(value);
    min_q.push_back(at_least);
  endfunction

  function automatic int outstanding();
    return exp_q.size();
  endfunction

  function automatic logic [31:0] line_value(input int sel);
    case (sel)
      0: return 32'(gpio_i);
      1: return 32'(gpio_en_i);
      2: return 32'(irq_i);
      3: return 32'(msip_i);
      default: return 32'(timer_intr_i);
    endcase
  endfunction

  function automatic string line_name(input int sel);
    case (sel)
      0: return "gpio_o";
      1: return "gpio_en_o";
      2: return "irq_o";
      3: return "msip_o";
      default: return "timer_intr_o";
    endcase
  endfunction

  function automatic void compare_line(input int sel, input logic [31:0] expected);
    checks++;
    if (line_value(sel) !== expected) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, line_name(sel),
               line_value(sel), expected);
      count_error();
    end
  endfunction

  function automatic void note_timeout(input string what);
    $display("Timed out at %0t: %s", $time, what);
    count_error();
  endfunction

  function automatic void finish_test(input int num, input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d mismatches", num, name, test_errors);
    end
    test_errors = 0;
  endfunction

  function automatic void report_counts();
    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
             checks, errors);
  endfunction

  function automatic int error_count();
    return errors;
  endfunction

endmodule

`default_nettype wire

// ==== sim/periph_assertions.sv ====
// OBI protocol and reset assertions for the peripheral subsystem
`default_nettype none

module periph_assertions (
  input logic clk_i,
  input logic arst_n_i,
  input logic req_i,
  input logic gnt_o,
  input logic rvalid_o,
  input logic irq_o,
  input logic msip_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  // One response per grant, in the following cycle
  assert property (@(posedge clk_i) disable iff (!arst_n_i) rvalid_o == $past(gnt_o))
    else begin
      failures++;
      $error("rvalid_o does not follow gnt_o by exactly one cycle");
    end

  assert property (@(posedge clk_i) gnt_o |-> req_i)
    else begin
      failures++;
      $error("gnt_o raised without req_i");
    end

  assert property (@(posedge clk_i) !arst_n_i |-> (!irq_o && !msip_o))
    else begin
      failures++;
      $error("irq_o or msip_o high during reset");
    end

endmodule

bind peripheral_subsystem periph_assertions periph_assertions_i (.*);

`default_nettype wire

// ==== sim/tb_peripheral_subsystem.sv ====
// Testbench for the peripheral subsystem
// Applies a table of bus accesses and pin changes, checked by periph_checker
`default_nettype none

module tb_peripheral_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  import periph_pkg::*;

  localparam int GPIO_W    = 8;
  localparam int NUM_EXT   = 4;
  localparam int TIMER_SRC = GPIO_W + 1;
  localparam int EXT_BASE  = GPIO_W + 2;
  localparam int PIN       = 5;
  localparam int TIMEOUT   = 200;
  localparam int SETTLE    = 3;
  localparam logic [31:0] PIN_MASK = (32'd1 << GPIO_W) - 1;

  // For WAIT and LINE rows the address field selects the output line
  localparam logic [2:0] OP_READ     = 3'd0;
  localparam logic [2:0] OP_READ_MIN = 3'd1;
  localparam logic [2:0] OP_WRITE    = 3'd2;
  localparam logic [2:0] OP_PINS     = 3'd3;
  localparam logic [2:0] OP_EXT      = 3'd4;
  localparam logic [2:0] OP_WAIT     = 3'd5;
  localparam logic [2:0] OP_LINE     = 3'd6;

  localparam logic [31:0] L_GPIO  = 32'd0;
  localparam logic [31:0] L_OE    = 32'd1;
  localparam logic [31:0] L_IRQ   = 32'd2;
  localparam logic [31:0] L_MSIP  = 32'd3;
  localparam logic [31:0] L_TIMER = 32'd4;

  typedef struct packed {
    logic [3:0]  test;
    logic [2:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
  } row_t;

  logic               clk;
  logic               arst_n;
  logic               req;
  logic [31:0]        addr;
  logic               we;
  logic [3:0]         be;
  logic [31:0]        wdata;
  logic               gnt;
  logic               rvalid;
  logic [31:0]        rdata;
  logic [GPIO_W-1:0]  gpio_in;
  logic [GPIO_W-1:0]  gpio_out;
  logic [GPIO_W-1:0]  gpio_en;
  logic [NUM_EXT-1:0] ext_intr;
  logic               irq;
  logic               msip;
  logic               timer_intr;

  row_t        rows[$];
  logic [31:0] lcg_state = 32'd65602;
  string       test_names[6] = '{"reset values", "gpio registers", "pin interrupt",
                                 "machine timer", "external lines and msip",
                                 "back-to-back and unmapped"};

  peripheral_subsystem #(
    .GPIO_W  (GPIO_W),
    .NUM_EXT (NUM_EXT)
  ) dut_i (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .req_i        (req),
    .addr_i       (addr),
    .we_i         (we),
    .be_i         (be),
    .wdata_i      (wdata),
    .gnt_o        (gnt),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_en),
    .ext_intr_i   (ext_intr),
    .irq_o        (irq),
    .msip_o       (msip),
    .timer_intr_o (timer_intr)
  );

  periph_checker #(
    .GPIO_W (GPIO_W)
  ) chk_i (
    .clk_i        (clk),
    .rvalid_i     (rvalid),
    .rdata_i      (rdata),
    .gpio_i       (gpio_out),
    .gpio_en_i    (gpio_en),
    .irq_i        (irq),
    .msip_i       (msip),
    .timer_intr_i (timer_intr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Halves of the LCG state swapped so the low pin bits vary well
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic [31:0] make_addr(input logic [PAGE_W-1:0] page,
                                            input logic [IDX_W-1:0] idx,
                                            input logic [REG_WORD_W-1:0] word);
    periph_addr_u a;
    a.f.page   = page;
    a.f.idx    = idx;
    a.f.word   = word;
    a.f.offset = 2'b00;
    return a.raw;
  endfunction

  function automatic logic [31:0] reg_at(input logic [IDX_W-1:0] idx,
                                         input logic [REG_WORD_W-1:0] word);
    return make_addr(PERIPH_PAGE, idx, word);
  endfunction

  function automatic void add_row(input int test, input logic [2:0] op, input logic [31:0] a,
                                  input logic [31:0] data, input logic [31:0] expected);
    row_t r;
    r.test     = 4'(test);
    r.op       = op;
    r.addr     = a;
    r.data     = data;
    r.expected = expected;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    logic [31:0] out_val;
    logic [31:0] oe_val;
    logic [31:0] pin_val;
    logic [31:0] late_val;
    logic [31:0] junk_val;
    logic [31:0] ext_en;
    logic [31:0] bad_page;
    logic [31:0] bad_idx;
    out_val  = next_random();
    oe_val   = next_random();
    pin_val  = next_random() & PIN_MASK;
    late_val = next_random();
    junk_val = next_random();
    ext_en   = (32'd1 << (EXT_BASE + 1)) | (32'd1 << (EXT_BASE + 3));
    bad_page = make_addr(20'h12345, IDX_GPIO, GPIO_OUT);
    bad_idx  = make_addr(PERIPH_PAGE, 4'd7, GPIO_OUT);

    add_row(1, OP_LINE, L_IRQ, 0, 0);
    add_row(1, OP_LINE, L_MSIP, 0, 0);
    add_row(1, OP_LINE, L_TIMER, 0, 0);
    add_row(1, OP_LINE, L_GPIO, 0, 0);
    add_row(1, OP_LINE, L_OE, 0, 0);
    add_row(1, OP_READ, reg_at(IDX_GPIO, GPIO_OUT), 0, 0);
    add_row(1, OP_READ, reg_at(IDX_IRQ, IRQ_ENABLE), 0, 0);
    add_row(1, OP_READ, reg_at(IDX_TIMER, TMR_CTRL), 0, 0);

    add_row(2, OP_WRITE, reg_at(IDX_GPIO, GPIO_OUT), out_val, 0);
    add_row(2, OP_WRITE, reg_at(IDX_GPIO, GPIO_OUT_EN), oe_val, 0);
    add_row(2, OP_READ, reg_at(IDX_GPIO, GPIO_OUT), 0, out_val);
    add_row(2, OP_READ, reg_at(IDX_GPIO, GPIO_OUT_EN), 0, oe_val);
    add_row(2, OP_LINE, L_GPIO, 0, out_val & PIN_MASK);
    add_row(2, OP_LINE, L_OE, 0, oe_val & PIN_MASK);
    add_row(2, OP_PINS, 0, pin_val, 0);
    add_row(2, OP_READ, reg_at(IDX_GPIO, GPIO_IN), 0, pin_val);
    add_row(2, OP_PINS, 0, 0, 0);

    add_row(3, OP_WRITE, reg_at(IDX_GPIO, GPIO_INTR_EN), 32'd1 << PIN, 0);
    add_row(3, OP_WRITE, reg_at(IDX_IRQ, IRQ_ENABLE), 32'd1 << (PIN + 1), 0);
    add_row(3, OP_PINS, 0, 32'd1 << PIN, 0);
    add_row(3, OP_WAIT, L_IRQ, 0, 1);
    add_row(3, OP_READ, reg_at(IDX_IRQ, IRQ_CLAIM), 0, PIN + 1);
    add_row(3, OP_WRITE, reg_at(IDX_GPIO, GPIO_INTR_STATUS), 32'd1 << PIN, 0);
    // Status was still high after the first claim, so the bit pends once more
    add_row(3, OP_READ, reg_at(IDX_IRQ, IRQ_CLAIM), 0, PIN + 1);
    add_row(3, OP_READ, reg_at(IDX_IRQ, IRQ_CLAIM), 0, 0);
    add_row(3, OP_LINE, L_IRQ, 0, 0);
    add_row(3, OP_PINS, 0, 0, 0);

    add_row(4, OP_WRITE, reg_at(IDX_TIMER, TMR_MTIME), 0, 0);
    add_row(4, OP_WRITE, reg_at(IDX_TIMER, TMR_MTIMECMP), 50, 0);
    add_row(4, OP_WRITE, reg_at(IDX_TIMER, TMR_CTRL), 3, 0);
    add_row(4, OP_WAIT, L_TIMER, 0, 1);
    add_row(4, OP_READ_MIN, reg_at(IDX_TIMER, TMR_MTIME), 0, 50);
    add_row(4, OP_LINE, L_IRQ, 0, 0);
    add_row(4, OP_WRITE, reg_at(IDX_IRQ, IRQ_ENABLE), 32'd1 << TIMER_SRC, 0);
    add_row(4, OP_LINE, L_IRQ, 0, 1);
    add_row(4, OP_WRITE, reg_at(IDX_TIMER, TMR_CTRL), 0, 0);
    add_row(4, OP_READ, reg_at(IDX_IRQ, IRQ_CLAIM), 0, TIMER_SRC);
    add_row(4, OP_LINE, L_TIMER, 0, 0);
    add_row(4, OP_LINE, L_IRQ, 0, 0);

    add_row(5, OP_WRITE, reg_at(IDX_IRQ, IRQ_ENABLE), ext_en, 0);
    add_row(5, OP_EXT, 0, 32'b1010, 0);
    add_row(5, OP_EXT, 0, 0, 0);
    add_row(5, OP_READ, reg_at(IDX_IRQ, IRQ_CLAIM), 0, EXT_BASE + 1);
    add_row(5, OP_READ, reg_at(IDX_IRQ, IRQ_CLAIM), 0, EXT_BASE + 3);
    add_row(5, OP_READ, reg_at(IDX_IRQ, IRQ_CLAIM), 0, 0);
    add_row(5, OP_LINE, L_IRQ, 0, 0);
    add_row(5, OP_WRITE, reg_at(IDX_IRQ, IRQ_MSIP), 1, 0);
    add_row(5, OP_LINE, L_MSIP, 0, 1);
    add_row(5, OP_WRITE, reg_at(IDX_IRQ, IRQ_MSIP), 0, 0);
    add_row(5, OP_LINE, L_MSIP, 0, 0);

    add_row(6, OP_WRITE, reg_at(IDX_GPIO, GPIO_OUT), late_val, 0);
    add_row(6, OP_WRITE, bad_page, junk_val, 0);
    add_row(6, OP_WRITE, bad_idx, junk_val, 0);
    add_row(6, OP_READ, bad_page, 0, 0);
    add_row(6, OP_READ, bad_idx, 0, 0);
    add_row(6, OP_READ, reg_at(IDX_GPIO, GPIO_OUT), 0, late_val);
    add_row(6, OP_READ, reg_at(IDX_IRQ, IRQ_ENABLE), 0, ext_en);
    add_row(6, OP_READ, reg_at(IDX_TIMER, TMR_MTIMECMP), 0, 50);
  endfunction

  task automatic apply_row(input row_t r);
    int waited;
    waited = 0;
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
    case (r.op)
      OP_READ, OP_READ_MIN, OP_WRITE: begin
        req   <= 1'b1;
        addr  <= r.addr;
        we    <= (r.op == OP_WRITE);
        wdata <= r.data;
        chk_i.expect_response(r.op == OP_WRITE ? 32'h0 : r.expected, r.op == OP_READ_MIN);
        // The request stays up until the grant is seen
        @(negedge clk);
        while (gnt !== 1'b1 && waited < TIMEOUT) begin
          @(negedge clk);
          waited++;
        end
        if (gnt !== 1'b1) begin
          chk_i.note_timeout($sformatf("request to %08h was not granted within %0d cycles",
                                       r.addr, TIMEOUT));
        end
      end
      OP_PINS: begin
        gpio_in <= r.data[GPIO_W-1:0];
        repeat (SETTLE) @(posedge clk);
      end
      OP_EXT: begin
        ext_intr <= r.data[NUM_EXT-1:0];
        repeat (SETTLE) @(posedge clk);
      end
      OP_WAIT: begin
        @(negedge clk);
        while (chk_i.line_value(r.addr) !== r.expected && waited < TIMEOUT) begin
          @(negedge clk);
          waited++;
        end
        if (chk_i.line_value(r.addr) !== r.expected) begin
          chk_i.note_timeout($sformatf("%s did not reach %0h within %0d cycles",
                                       chk_i.line_name(r.addr), r.expected, TIMEOUT));
        end
      end
      default: begin
        @(negedge clk);
        chk_i.compare_line(r.addr, r.expected);
      end
    endcase
  endtask

  // Let the last responses of a test drain before reporting it
  task automatic close_test(input int num);
    int waited;
    waited = 0;
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
    while (chk_i.outstanding() > 0 && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (chk_i.outstanding() > 0) begin
      chk_i.note_timeout($sformatf("%0d responses still missing in test %0d",
                                   chk_i.outstanding(), num));
    end
    chk_i.finish_test(num, test_names[num-1]);
  endtask

  initial begin : stimulus
    int current;
    arst_n   = 1'b0;
    req      = 1'b0;
    addr     = '0;
    we       = 1'b0;
    be       = 4'hf;
    wdata    = '0;
    gpio_in  = '0;
    ext_intr = '0;
    build_table();
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    current = rows[0].test;
    foreach (rows[i]) begin
      if (rows[i].test != current) begin
        close_test(current);
        current = rows[i].test;
      end
      apply_row(rows[i]);
    end
    close_test(current);
    chk_i.report_counts();
    if (chk_i.error_count() == 0 && dut_i.periph_assertions_i.failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/periph_pkg.sv
logic/obi_reg_bridge.sv
logic/periph_reg_decode.sv
logic/gpio_block.sv
logic/timer_block.sv
logic/irq_ctrl.sv
logic/peripheral_subsystem.sv
sim/periph_checker.sv
sim/periph_assertions.sv
sim/tb_peripheral_subsystem.sv
